//--- Bender.yml
package:
  name: soc_bus

sources:
  - soc_bus_pkg.sv
  - dev_bus_if.sv
  - data_bus.sv
  - sram_ctrl.sv
  - ticker.sv
  - gpio_regs.sv
  - soc_bus_top.sv
  - target: test
    files:
      - tb_soc_bus_asserts.sv
      - tb_soc_bus.sv

//--- data_bus.sv
//**************************************************************************
// Data-bus decoder. Matches the processor address against the fixed map,
// raises the strobe of the addressed device only, and returns its read
// data and stall. Unmapped reads give zero, unmapped writes are dropped.
//**************************************************************************

`timescale 1ns/1ps

module data_bus (
    input  logic                   clk,
    input  logic                   rst_i,

    input  soc_bus_pkg::bus_addr_t bus_addr_i,
    input  soc_bus_pkg::bus_data_t bus_wdata_i,
    input  soc_bus_pkg::byte_en_t  bus_be_i,
    input  logic                   bus_rd_i,
    input  logic                   bus_wr_i,
    output soc_bus_pkg::bus_data_t bus_rdata_o,
    output logic                   bus_stall_o,

    input  logic                   ram_stall_i,
    dev_bus_if.master              ram_o,
    dev_bus_if.master              tick_o,
    dev_bus_if.master              gpio_o
);
    import soc_bus_pkg::*;

    logic ram_hit;
    logic tick_hit;
    logic gpio_hit;
    logic any_hit;
    logic unmapped_wr_q;    // last cycle held a write to no device

    assign ram_hit  = (bus_addr_i & RAM_MASK) == RAM_BASE;
    assign tick_hit = (bus_addr_i & REG_WIN_MASK) == TICKER_BASE;
    assign gpio_hit = (bus_addr_i & REG_WIN_MASK) == GPIO_BASE;
    assign any_hit  = ram_hit | tick_hit | gpio_hit;

    // RAM sees the 8 MB offset, register blocks the low byte only
    assign ram_o.off   = dev_off_t'(bus_addr_i & ~RAM_MASK);
    assign ram_o.wdata = bus_wdata_i;
    assign ram_o.be    = bus_be_i;
    assign ram_o.rd    = bus_rd_i & ram_hit;
    assign ram_o.wr    = bus_wr_i & ram_hit;

    assign tick_o.off   = dev_off_t'(bus_addr_i & ~REG_WIN_MASK);
    assign tick_o.wdata = bus_wdata_i;
    assign tick_o.be    = bus_be_i;
    assign tick_o.rd    = bus_rd_i & tick_hit;
    assign tick_o.wr    = bus_wr_i & tick_hit;

    assign gpio_o.off   = dev_off_t'(bus_addr_i & ~REG_WIN_MASK);
    assign gpio_o.wdata = bus_wdata_i;
    assign gpio_o.be    = bus_be_i;
    assign gpio_o.rd    = bus_rd_i & gpio_hit;
    assign gpio_o.wr    = bus_wr_i & gpio_hit;

    always_comb begin
        if (ram_hit) begin
            bus_rdata_o = ram_o.rdata;
        end else if (tick_hit) begin
            bus_rdata_o = tick_o.rdata;
        end else if (gpio_hit) begin
            bus_rdata_o = gpio_o.rdata;
        end else begin
            bus_rdata_o = '0;   // unmapped
        end
    end

    assign bus_stall_o = ram_hit & ram_stall_i;  // only the RAM stalls

    always_ff @(posedge clk) begin
        if (rst_i) begin
            unmapped_wr_q <= 1'b0;
        end else begin
            unmapped_wr_q <= bus_wr_i & ~any_hit;
        end
    end

endmodule

//--- dev_bus_if.sv
//**************************************************************************
// One decoded device access between the bus decoder and a single device.
// The decoder takes the master modport, the device the device modport.
//**************************************************************************

`timescale 1ns/1ps

interface dev_bus_if;
    import soc_bus_pkg::*;

    dev_off_t  off;     // offset inside the device window
    bus_data_t wdata;
    byte_en_t  be;
    logic      rd;      // high only while this device is addressed
    logic      wr;
    bus_data_t rdata;   // driven by the device

    modport master (
        output off,
        output wdata,
        output be,
        output rd,
        output wr,
        input  rdata
    );

    modport device (
        input  off,
        input  wdata,
        input  be,
        input  rd,
        input  wr,
        output rdata
    );

endinterface

//--- gpio_regs.sv
//**************************************************************************
// GPIO register block. Offset 0 is the byte-writable output register,
// offset 4 reads the input pins after a two-flop synchronizer.
//**************************************************************************

`timescale 1ns/1ps

module gpio_regs (
    input  logic                   clk,
    input  logic                   rst_i,
    dev_bus_if.device              bus_i,
    input  soc_bus_pkg::bus_data_t gpio_in_i,
    output soc_bus_pkg::bus_data_t gpio_out_o
);
    import soc_bus_pkg::*;

    bus_data_t out_q;
    bus_data_t in_meta_q;   // first synchronizer stage
    bus_data_t in_sync_q;
    logic      out_wr;

    assign out_wr = bus_i.wr & (bus_i.off == GPIO_OUT_OFF);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q <= '0;
        end else if (out_wr) begin
            for (int i = 0; i < 4; i++) begin
                if (bus_i.be[i]) begin
                    out_q[8*i +: 8] <= bus_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // pins are asynchronous to clk
    always_ff @(posedge clk) begin
        if (rst_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_comb begin
        bus_i.rdata = '0;
        if (bus_i.rd) begin
            if (bus_i.off == GPIO_OUT_OFF) begin
                bus_i.rdata = out_q;
            end else if (bus_i.off == GPIO_IN_OFF) begin
                bus_i.rdata = in_sync_q;
            end
        end
    end

    assign gpio_out_o = out_q;

endmodule

//--- soc_bus_pkg.sv
//**************************************************************************
// Shared address map, bus word types and SRAM controller state encoding
// for the data-bus subsystem. Modules import it inside their bodies.
//**************************************************************************

package soc_bus_pkg;

    typedef logic [31:0] bus_addr_t;    // processor byte address
    typedef logic [31:0] bus_data_t;    // one bus data word
    typedef logic [3:0]  byte_en_t;     // per-byte write enables
    typedef logic [23:0] dev_off_t;     // offset inside a device window
    typedef logic [19:0] sram_addr_t;   // word address on one SRAM bank

    // RAM covers 8 MB, two 4 MB banks
    localparam bus_addr_t RAM_BASE     = 32'h8000_0000;
    localparam bus_addr_t RAM_MASK     = 32'hff80_0000;

    // 256-byte register windows
    localparam bus_addr_t TICKER_BASE  = 32'hbfd0_0400;
    localparam bus_addr_t GPIO_BASE    = 32'hbfd0_0500;
    localparam bus_addr_t REG_WIN_MASK = 32'hffff_ff00;

    localparam int RAM_BANK_BIT = 22;   // set selects the ext bank

    localparam dev_off_t GPIO_OUT_OFF = 24'h00_0000;
    localparam dev_off_t GPIO_IN_OFF  = 24'h00_0004;

    // S_READ holds registered read data for the closing cycle,
    // S_MERGE drives the merged word of a partial write
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_READ  = 2'd1,
        S_MERGE = 2'd2
    } sram_state_t;

endpackage

//--- soc_bus_top.sv
//**************************************************************************
// Data-bus subsystem top. The bus master drives the plain bus ports;
// the decoder fans out to the SRAM controller, ticker and GPIO block.
//**************************************************************************

`timescale 1ns/1ps

module soc_bus_top (
    input  logic                    clk,
    input  logic                    rst_i,

    input  soc_bus_pkg::bus_addr_t  bus_addr_i,
    input  soc_bus_pkg::bus_data_t  bus_wdata_i,
    input  soc_bus_pkg::byte_en_t   bus_be_i,
    input  logic                    bus_rd_i,
    input  logic                    bus_wr_i,
    output soc_bus_pkg::bus_data_t  bus_rdata_o,
    output logic                    bus_stall_o,

    output soc_bus_pkg::sram_addr_t base_ram_addr_o,
    input  soc_bus_pkg::bus_data_t  base_ram_data_i,
    output soc_bus_pkg::bus_data_t  base_ram_data_o,
    output logic                    base_ram_data_oe_o,
    output logic                    base_ram_ce_n_o,
    output logic                    base_ram_oe_n_o,
    output logic                    base_ram_we_n_o,

    output soc_bus_pkg::sram_addr_t ext_ram_addr_o,
    input  soc_bus_pkg::bus_data_t  ext_ram_data_i,
    output soc_bus_pkg::bus_data_t  ext_ram_data_o,
    output logic                    ext_ram_data_oe_o,
    output logic                    ext_ram_ce_n_o,
    output logic                    ext_ram_oe_n_o,
    output logic                    ext_ram_we_n_o,

    input  soc_bus_pkg::bus_data_t  gpio_in_i,
    output soc_bus_pkg::bus_data_t  gpio_out_o
);

    logic ram_stall;

    dev_bus_if ram_bus ();
    dev_bus_if tick_bus ();
    dev_bus_if gpio_bus ();

    data_bus dbus0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_be_i    (bus_be_i),
        .bus_rd_i    (bus_rd_i),
        .bus_wr_i    (bus_wr_i),
        .bus_rdata_o (bus_rdata_o),
        .bus_stall_o (bus_stall_o),
        .ram_stall_i (ram_stall),
        .ram_o       (ram_bus),
        .tick_o      (tick_bus),
        .gpio_o      (gpio_bus)
    );

    sram_ctrl sram0 (
        .clk                (clk),
        .rst_i              (rst_i),
        .bus_i              (ram_bus),
        .stall_o            (ram_stall),
        .base_ram_addr_o    (base_ram_addr_o),
        .base_ram_data_i    (base_ram_data_i),
        .base_ram_data_o    (base_ram_data_o),
        .base_ram_data_oe_o (base_ram_data_oe_o),
        .base_ram_ce_n_o    (base_ram_ce_n_o),
        .base_ram_oe_n_o    (base_ram_oe_n_o),
        .base_ram_we_n_o    (base_ram_we_n_o),
        .ext_ram_addr_o     (ext_ram_addr_o),
        .ext_ram_data_i     (ext_ram_data_i),
        .ext_ram_data_o     (ext_ram_data_o),
        .ext_ram_data_oe_o  (ext_ram_data_oe_o),
        .ext_ram_ce_n_o     (ext_ram_ce_n_o),
        .ext_ram_oe_n_o     (ext_ram_oe_n_o),
        .ext_ram_we_n_o     (ext_ram_we_n_o)
    );

    ticker ticker0 (
        .clk   (clk),
        .rst_i (rst_i),
        .bus_i (tick_bus)
    );

    gpio_regs gpio0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .bus_i      (gpio_bus),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

endmodule

//--- sram_ctrl.sv
//**************************************************************************
// Two-bank asynchronous SRAM controller. Offset bit 22 picks the bank.
// Reads take two cycles with registered data; full-word writes take one,
// partial writes read the word first and write the merged bytes after.
//**************************************************************************

`timescale 1ns/1ps

module sram_ctrl (
    input  logic                    clk,
    input  logic                    rst_i,
    dev_bus_if.device               bus_i,
    output logic                    stall_o,

    output soc_bus_pkg::sram_addr_t base_ram_addr_o,
    input  soc_bus_pkg::bus_data_t  base_ram_data_i,
    output soc_bus_pkg::bus_data_t  base_ram_data_o,
    output logic                    base_ram_data_oe_o,
    output logic                    base_ram_ce_n_o,
    output logic                    base_ram_oe_n_o,
    output logic                    base_ram_we_n_o,

    output soc_bus_pkg::sram_addr_t ext_ram_addr_o,
    input  soc_bus_pkg::bus_data_t  ext_ram_data_i,
    output soc_bus_pkg::bus_data_t  ext_ram_data_o,
    output logic                    ext_ram_data_oe_o,
    output logic                    ext_ram_ce_n_o,
    output logic                    ext_ram_oe_n_o,
    output logic                    ext_ram_we_n_o
);
    import soc_bus_pkg::*;

    sram_state_t state_q;
    sram_state_t state_d;
    bus_data_t   rdata_q;       // word captured from the bank
    bus_data_t   merge_data;
    bus_data_t   bank_data;
    bus_data_t   write_data;
    logic        ext_sel;
    logic        full_wr;
    logic        part_wr;
    logic        rd_phase;      // bank read this cycle
    logic        wr_phase;      // bank write this cycle

    assign ext_sel = bus_i.off[RAM_BANK_BIT];
    assign full_wr = bus_i.wr & (bus_i.be == 4'hf);
    assign part_wr = bus_i.wr & ~full_wr;

    // a read, or the first half of a partial write, samples the bank
    assign rd_phase = (state_q == S_IDLE) & (bus_i.rd | part_wr);
    assign wr_phase = ((state_q == S_IDLE) & full_wr) |
                      ((state_q == S_MERGE) & bus_i.wr);

    assign stall_o = rd_phase;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merge_data[8*i +: 8] = bus_i.be[i] ? bus_i.wdata[8*i +: 8] : rdata_q[8*i +: 8];
        end
    end

    assign write_data = (state_q == S_MERGE) ? merge_data : bus_i.wdata;
    assign bank_data  = ext_sel ? ext_ram_data_i : base_ram_data_i;

    assign base_ram_addr_o    = sram_addr_t'(bus_i.off[21:2]);
    assign base_ram_data_o    = write_data;
    assign base_ram_data_oe_o = wr_phase & ~ext_sel;
    assign base_ram_ce_n_o    = ~((rd_phase | wr_phase) & ~ext_sel);
    assign base_ram_oe_n_o    = ~(rd_phase & ~ext_sel);
    assign base_ram_we_n_o    = ~(wr_phase & ~ext_sel);

    assign ext_ram_addr_o    = sram_addr_t'(bus_i.off[21:2]);
    assign ext_ram_data_o    = write_data;
    assign ext_ram_data_oe_o = wr_phase & ext_sel;
    assign ext_ram_ce_n_o    = ~((rd_phase | wr_phase) & ext_sel);
    assign ext_ram_oe_n_o    = ~(rd_phase & ext_sel);
    assign ext_ram_we_n_o    = ~(wr_phase & ext_sel);

    assign bus_i.rdata = rdata_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (bus_i.rd) begin
                    state_d = S_READ;
                end else if (part_wr) begin
                    state_d = S_MERGE;
                end
            end
            S_READ:  state_d = S_IDLE;     // data returned this cycle
            S_MERGE: state_d = S_IDLE;     // merged word written this cycle
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_phase) begin
            rdata_q <= bank_data;
        end
    end

endmodule

//--- tb_soc_bus.sv
//**************************************************************************
// Testbench for the data-bus subsystem. Acts as bus master, models both
// SRAM banks and compares read data against a scoreboard.
//**************************************************************************

`timescale 1ns/1ps

module tb_soc_bus;
    import soc_bus_pkg::*;

    localparam int N_WORDS        = 64;
    localparam int TIMEOUT_CYCLES = 2000;   // about four times the test length

    logic       clk;
    logic       rst;
    bus_addr_t  bus_addr;
    bus_data_t  bus_wdata;
    byte_en_t   bus_be;
    logic       bus_rd;
    logic       bus_wr;
    bus_data_t  bus_rdata;
    logic       bus_stall;
    sram_addr_t base_addr;
    bus_data_t  base_rdata;
    bus_data_t  base_wdata;
    logic       base_oe;
    logic       base_ce_n;
    logic       base_oe_n;
    logic       base_we_n;
    sram_addr_t ext_addr;
    bus_data_t  ext_rdata;
    bus_data_t  ext_wdata;
    logic       ext_oe;
    logic       ext_ce_n;
    logic       ext_oe_n;
    logic       ext_we_n;
    bus_data_t  gpio_in;
    bus_data_t  gpio_out;

    bus_data_t  base_mem [0:(1 << 20) - 1];
    bus_data_t  ext_mem [0:(1 << 20) - 1];
    bus_addr_t  ram_addr [N_WORDS];
    bus_data_t  ram_exp [N_WORDS];     // last value written per address
    bus_data_t  rng_state;
    int         err_cnt = 0;
    int         cycle_cnt = 0;

    soc_bus_top dut0 (
        .clk (clk), .rst_i (rst),
        .bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata), .bus_be_i (bus_be),
        .bus_rd_i (bus_rd), .bus_wr_i (bus_wr),
        .bus_rdata_o (bus_rdata), .bus_stall_o (bus_stall),
        .base_ram_addr_o (base_addr), .base_ram_data_i (base_rdata),
        .base_ram_data_o (base_wdata), .base_ram_data_oe_o (base_oe),
        .base_ram_ce_n_o (base_ce_n), .base_ram_oe_n_o (base_oe_n),
        .base_ram_we_n_o (base_we_n),
        .ext_ram_addr_o (ext_addr), .ext_ram_data_i (ext_rdata),
        .ext_ram_data_o (ext_wdata), .ext_ram_data_oe_o (ext_oe),
        .ext_ram_ce_n_o (ext_ce_n), .ext_ram_oe_n_o (ext_oe_n),
        .ext_ram_we_n_o (ext_we_n),
        .gpio_in_i (gpio_in), .gpio_out_o (gpio_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // asynchronous SRAM banks, combinational read
    assign base_rdata = (!base_ce_n && !base_oe_n) ? base_mem[base_addr] : '0;
    assign ext_rdata  = (!ext_ce_n && !ext_oe_n) ? ext_mem[ext_addr] : '0;

    always @(posedge clk) begin
        if (!base_ce_n && !base_we_n) begin
            base_mem[base_addr] <= base_wdata;
        end
        if (!ext_ce_n && !ext_we_n) begin
            ext_mem[ext_addr] <= ext_wdata;
        end
    end

    function automatic bus_data_t xorshift32(input bus_data_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bus_data_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic bus_data_t merge_bytes(input bus_data_t old_w, input bus_data_t new_w,
                                              input byte_en_t be);
        bus_data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input string test, input bus_data_t expected,
                               input bus_data_t actual);
        if (actual !== expected) begin
            err_cnt++;
            $display("ERROR %s: expected %08h, actual %08h", test, expected, actual);
        end
    endtask

    // entered 5 ns after a rising edge, leaves 5 ns after the closing edge
    task automatic bus_access(input bus_addr_t addr, input bus_data_t data, input byte_en_t be,
                              input logic is_wr, output bus_data_t rdata, output int cycles);
        logic stalled;
        bus_addr  = addr;
        bus_wdata = data;
        bus_be    = be;
        bus_rd    = ~is_wr;
        bus_wr    = is_wr;
        cycles    = 0;
        stalled   = 1'b1;
        while (stalled) begin
            @(negedge clk);             // mid-cycle, outputs settled
            stalled = bus_stall;
            rdata   = bus_rdata;
            cycles++;
            @(posedge clk);
        end
        #5;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
    endtask

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run timed out after %0d cycles without finishing the tests", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        bus_data_t rdata;
        bus_data_t wdata;
        bus_data_t tick_val;
        bus_data_t gpio_exp;
        byte_en_t  be;
        int        cycles;
        int        assert_fails;
        rng_state = 32'hb0e8;
        rst       = 1'b1;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_be    = '0;
        bus_rd    = 1'b0;
        bus_wr    = 1'b0;
        gpio_in   = '0;
        repeat (2) @(posedge clk);
        #5 rst = 1'b0;
        @(posedge clk);
        #5;

        // full-word writes, odd indices go to the ext bank
        for (int i = 0; i < N_WORDS; i++) begin
            wdata       = rand_word();
            ram_addr[i] = RAM_BASE | (bus_addr_t'(i % 2) << RAM_BANK_BIT) |
                          ((wdata & 32'h3ff) << 8) | (bus_addr_t'(i) << 2);
            ram_exp[i]  = rand_word();
            bus_access(ram_addr[i], ram_exp[i], 4'hf, 1'b1, rdata, cycles);
            check_value("ram full write cycles", 1, cycles);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            bus_access(ram_addr[i], '0, 4'h0, 1'b0, rdata, cycles);
            check_value("ram read", ram_exp[i], rdata);
            check_value("ram read cycles", 2, cycles);
        end

        // partial writes merge into the old word
        for (int i = 0; i < N_WORDS; i++) begin
            wdata      = rand_word();
            be         = wdata[3:0];
            wdata      = rand_word();
            ram_exp[i] = merge_bytes(ram_exp[i], wdata, be);
            bus_access(ram_addr[i], wdata, be, 1'b1, rdata, cycles);
            check_value("ram partial write cycles", (be == 4'hf) ? 1 : 2, cycles);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            bus_access(ram_addr[i], '0, 4'h0, 1'b0, rdata, cycles);
            check_value("ram partial read", ram_exp[i], rdata);
        end

        // ticker load, then back-to-back reads count up
        tick_val = rand_word();
        bus_access(TICKER_BASE, tick_val, 4'hf, 1'b1, rdata, cycles);
        for (int i = 0; i < 4; i++) begin
            bus_access(TICKER_BASE, '0, 4'h0, 1'b0, rdata, cycles);
            check_value("ticker read", tick_val + bus_data_t'(i), rdata);
        end

        gpio_exp = rand_word();
        bus_access(GPIO_BASE, gpio_exp, 4'hf, 1'b1, rdata, cycles);
        for (int i = 0; i < 6; i++) begin
            wdata    = rand_word();
            be       = wdata[7:4];
            wdata    = rand_word();
            gpio_exp = merge_bytes(gpio_exp, wdata, be);
            bus_access(GPIO_BASE, wdata, be, 1'b1, rdata, cycles);
            bus_access(GPIO_BASE, '0, 4'h0, 1'b0, rdata, cycles);
            check_value("gpio out read", gpio_exp, rdata);
            check_value("gpio out pins", gpio_exp, gpio_out);
        end
        gpio_in = rand_word();
        repeat (3) @(posedge clk);      // through both synchronizer stages
        #5;
        bus_access(GPIO_BASE + 32'd4, '0, 4'h0, 1'b0, rdata, cycles);
        check_value("gpio in read", gpio_in, rdata);

        // unmapped space, including RAM aliases just outside the window
        bus_access(32'h1000_0000, '0, 4'h0, 1'b0, rdata, cycles);
        check_value("unmapped read", 0, rdata);
        bus_access(32'hbfd0_0600, '0, 4'h0, 1'b0, rdata, cycles);
        check_value("unmapped reg read", 0, rdata);
        bus_access(32'hbfd0_0600, rand_word(), 4'hf, 1'b1, rdata, cycles);
        bus_access(ram_addr[0] ^ 32'h0080_0000, rand_word(), 4'hf, 1'b1, rdata, cycles);
        bus_access(ram_addr[1] ^ 32'h0080_0000, rand_word(), 4'h3, 1'b1, rdata, cycles);
        check_value("unmapped write gpio", gpio_exp, gpio_out);
        for (int i = 0; i < 2; i++) begin
            bus_access(ram_addr[i], '0, 4'h0, 1'b0, rdata, cycles);
            check_value("unmapped write ram", ram_exp[i], rdata);
        end

        repeat (3) @(posedge clk);
        assert_fails = dut0.asserts0.fail_cnt;
        $display("Checks done: %0d read errors, %0d assertion failures",
                 err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb_soc_bus_asserts.sv
//**************************************************************************
// Protocol and data rules on the top-level ports, bound into soc_bus_top.
// Each failure increments fail_cnt, which the testbench reads at the end.
//**************************************************************************

`timescale 1ns/1ps

module tb_soc_bus_asserts (
    input logic                    clk,
    input logic                    rst_i,
    input soc_bus_pkg::bus_addr_t  bus_addr_i,
    input soc_bus_pkg::bus_data_t  bus_wdata_i,
    input soc_bus_pkg::byte_en_t   bus_be_i,
    input logic                    bus_rd_i,
    input logic                    bus_wr_i,
    input logic                    bus_stall_i,
    input logic                    base_ce_n_i,
    input logic                    base_we_n_i,
    input logic                    base_oe_i,
    input logic                    ext_ce_n_i,
    input logic                    ext_we_n_i,
    input logic                    ext_oe_i,
    input soc_bus_pkg::bus_data_t  gpio_out_i,
    input soc_bus_pkg::sram_state_t sram_state_i,
    input logic                    unmapped_wr_i
);
    import soc_bus_pkg::*;

    int   fail_cnt = 0;
    logic ram_hit;
    logic mapped;

    assign ram_hit = (bus_addr_i & RAM_MASK) == RAM_BASE;
    assign mapped  = ram_hit | ((bus_addr_i & REG_WIN_MASK) == TICKER_BASE) |
                     ((bus_addr_i & REG_WIN_MASK) == GPIO_BASE);

    a_reset_vals: assert property (@(posedge clk) rst_i |=>
        (!bus_stall_i && gpio_out_i == '0 && base_ce_n_i && ext_ce_n_i &&
         base_we_n_i && ext_we_n_i && !base_oe_i && !ext_oe_i))
        else begin fail_cnt++; $error("outputs not idle after reset"); end
    a_one_bank: assert property (@(posedge clk) disable iff (rst_i) base_ce_n_i || ext_ce_n_i)
        else begin fail_cnt++; $error("both SRAM chip enables low"); end
    a_base_we_oe: assert property (@(posedge clk) disable iff (rst_i) !base_we_n_i |-> base_oe_i)
        else begin fail_cnt++; $error("base we_n low with data output disabled"); end
    a_ext_we_oe: assert property (@(posedge clk) disable iff (rst_i) !ext_we_n_i |-> ext_oe_i)
        else begin fail_cnt++; $error("ext we_n low with data output disabled"); end
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst_i) !(bus_rd_i && bus_wr_i))
        else begin fail_cnt++; $error("master raised read and write together"); end
    a_stall_once: assert property (@(posedge clk) disable iff (rst_i) bus_stall_i |=> !bus_stall_i)
        else begin fail_cnt++; $error("stall held for more than one cycle"); end
    a_master_hold: assert property (@(posedge clk) disable iff (rst_i) bus_stall_i |=>
        ($stable(bus_addr_i) && $stable(bus_wdata_i) && $stable(bus_be_i) &&
         $stable(bus_rd_i) && $stable(bus_wr_i)))
        else begin fail_cnt++; $error("master changed the bus during a stall"); end
    a_read_stall: assert property (@(posedge clk) disable iff (rst_i)
        (bus_rd_i && ram_hit && !$past(bus_stall_i)) |-> bus_stall_i)
        else begin fail_cnt++; $error("RAM read did not stall in its first cycle"); end
    a_full_wr: assert property (@(posedge clk) disable iff (rst_i)
        (bus_wr_i && ram_hit && bus_be_i == 4'hf) |-> !bus_stall_i)
        else begin fail_cnt++; $error("full-word RAM write stalled"); end
    a_part_wr: assert property (@(posedge clk) disable iff (rst_i)
        (bus_wr_i && ram_hit && bus_be_i != 4'hf && !$past(bus_stall_i)) |-> bus_stall_i)
        else begin fail_cnt++; $error("partial RAM write did not stall first"); end
    a_merge: assert property (@(posedge clk) disable iff (rst_i) sram_state_i == S_MERGE |->
        ((!base_we_n_i || !ext_we_n_i) && !bus_stall_i))
        else begin fail_cnt++; $error("merge cycle wrote no bank or stalled"); end
    a_unmapped_ram: assert property (@(posedge clk) disable iff (rst_i)
        (bus_wr_i && !mapped) |-> (base_we_n_i && ext_we_n_i))
        else begin fail_cnt++; $error("unmapped write reached an SRAM bank"); end
    a_unmapped_gpio: assert property (@(posedge clk) disable iff (rst_i)
        unmapped_wr_i |-> $stable(gpio_out_i))
        else begin fail_cnt++; $error("unmapped write changed the GPIO outputs"); end

endmodule

bind soc_bus_top tb_soc_bus_asserts asserts0 (
    .clk           (clk),
    .rst_i         (rst_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_be_i      (bus_be_i),
    .bus_rd_i      (bus_rd_i),
    .bus_wr_i      (bus_wr_i),
    .bus_stall_i   (bus_stall_o),
    .base_ce_n_i   (base_ram_ce_n_o),
    .base_we_n_i   (base_ram_we_n_o),
    .base_oe_i     (base_ram_data_oe_o),
    .ext_ce_n_i    (ext_ram_ce_n_o),
    .ext_we_n_i    (ext_ram_we_n_o),
    .ext_oe_i      (ext_ram_data_oe_o),
    .gpio_out_i    (gpio_out_o),
    .sram_state_i  (sram0.state_q),
    .unmapped_wr_i (dbus0.unmapped_wr_q)
);

//--- ticker.sv
//**************************************************************************
// Free-running 32-bit cycle counter at offset 0 of the ticker window.
// A write loads the count, which then keeps counting from that value.
//**************************************************************************

`timescale 1ns/1ps

module ticker (
    input  logic      clk,
    input  logic      rst_i,
    dev_bus_if.device bus_i
);
    import soc_bus_pkg::*;

    bus_data_t count_q;
    logic      cnt_sel;   // offset 0 addressed
    logic      load;

    assign cnt_sel = (bus_i.off == '0);
    assign load    = bus_i.wr & cnt_sel;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= bus_i.wdata;     // load replaces the increment
        end else begin
            count_q <= count_q + 32'd1;
        end
    end

    // other offsets read as zero
    assign bus_i.rdata = (bus_i.rd & cnt_sel) ? count_q : '0;

endmodule

//--- verilog.f
soc_bus_pkg.sv
dev_bus_if.sv
data_bus.sv
sram_ctrl.sv
ticker.sv
gpio_regs.sv
soc_bus_top.sv
tb_soc_bus_asserts.sv
tb_soc_bus.sv
